// ==== Bender.yml ====
package:
  name: dual_issue_core

sources:
  - rtl/isa_pkg.sv
  - rtl/core_pkg.sv
  - rtl/issue_unit.sv
  - rtl/exec_lane.sv
  - rtl/register_file.sv
  - rtl/dual_issue_core.sv
  - target: test
    files:
      - testbench/core_props.sv
      - testbench/tb_dual_issue_core.sv

// ==== rtl/core_pkg.sv ====
`default_nettype none

package core_pkg;

  localparam int NUM_LANES  = 2;
  localparam int DATA_WIDTH = 32;

  // register 0 reads as zero
  localparam int NUM_REGS   = 32;

  // issue_second while the held half of a split pair goes out
  typedef enum logic {
    issue_pair,
    issue_second
  } issue_state_e;

endpackage

`default_nettype wire

// ==== rtl/dual_issue_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module dual_issue_core
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      inst_valid,
  input  logic [INST_WIDTH-1:0]     inst0,
  input  logic [INST_WIDTH-1:0]     inst1,
  output logic                      stall,
  output logic                      wb_valid [NUM_LANES],
  output logic [REG_ADDR_WIDTH-1:0] wb_reg   [NUM_LANES],
  output logic [DATA_WIDTH-1:0]     wb_data  [NUM_LANES]
);

  opcode_e                   lane_op     [NUM_LANES];
  logic [REG_ADDR_WIDTH-1:0] lane_rs     [NUM_LANES];
  logic [REG_ADDR_WIDTH-1:0] lane_rt     [NUM_LANES];
  logic [REG_ADDR_WIDTH-1:0] lane_dest   [NUM_LANES];
  logic [DATA_WIDTH-1:0]     lane_imm    [NUM_LANES];
  logic                      lane_we     [NUM_LANES];
  logic [DATA_WIDTH-1:0]     rs_data     [NUM_LANES];
  logic [DATA_WIDTH-1:0]     rt_data     [NUM_LANES];
  logic [DATA_WIDTH-1:0]     result      [NUM_LANES];
  logic [REG_ADDR_WIDTH-1:0] result_dest [NUM_LANES];
  logic                      result_we   [NUM_LANES];

  issue_unit issue_unit_inst (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst0      (inst0),
    .inst1      (inst1),
    .stall      (stall),
    .lane_op    (lane_op),
    .lane_rs    (lane_rs),
    .lane_rt    (lane_rt),
    .lane_dest  (lane_dest),
    .lane_imm   (lane_imm),
    .lane_we    (lane_we)
  );

  // every lane sees all result registers
  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    exec_lane exec_lane_inst (
      .clk         (clk),
      .reset       (reset),
      .op          (lane_op[g]),
      .rs          (lane_rs[g]),
      .rt          (lane_rt[g]),
      .dest        (lane_dest[g]),
      .imm         (lane_imm[g]),
      .we          (lane_we[g]),
      .rs_data     (rs_data[g]),
      .rt_data     (rt_data[g]),
      .fwd_result  (result),
      .fwd_dest    (result_dest),
      .fwd_we      (result_we),
      .result      (result[g]),
      .result_dest (result_dest[g]),
      .result_we   (result_we[g])
    );
  end

  register_file register_file_inst (
    .clk       (clk),
    .reset     (reset),
    .rd_addr_a (lane_rs),
    .rd_addr_b (lane_rt),
    .rd_data_a (rs_data),
    .rd_data_b (rt_data),
    .wr_en     (result_we),
    .wr_addr   (result_dest),
    .wr_data   (result),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data)
  );

endmodule

`default_nettype wire

// ==== rtl/exec_lane.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_lane
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  opcode_e                   op,
  input  logic [REG_ADDR_WIDTH-1:0] rs,
  input  logic [REG_ADDR_WIDTH-1:0] rt,
  input  logic [REG_ADDR_WIDTH-1:0] dest,
  input  logic [DATA_WIDTH-1:0]     imm,
  input  logic                      we,
  input  logic [DATA_WIDTH-1:0]     rs_data,
  input  logic [DATA_WIDTH-1:0]     rt_data,
  input  logic [DATA_WIDTH-1:0]     fwd_result [NUM_LANES],
  input  logic [REG_ADDR_WIDTH-1:0] fwd_dest   [NUM_LANES],
  input  logic                      fwd_we     [NUM_LANES],
  output logic [DATA_WIDTH-1:0]     result,
  output logic [REG_ADDR_WIDTH-1:0] result_dest,
  output logic                      result_we
);

  logic [DATA_WIDTH-1:0] opnd_a;
  logic [DATA_WIDTH-1:0] opnd_b;
  logic [DATA_WIDTH-1:0] alu_b;
  logic [DATA_WIDTH-1:0] alu_out;

  //////////////////////////////
  // operand forwarding

  // later lanes are younger, so the last match wins
  always_comb begin
    opnd_a = rs_data;
    opnd_b = rt_data;
    for (int i = 0; i < NUM_LANES; i++) begin
      if (fwd_we[i] && (fwd_dest[i] == rs)) begin
        opnd_a = fwd_result[i];
      end
      if (fwd_we[i] && (fwd_dest[i] == rt)) begin
        opnd_b = fwd_result[i];
      end
    end
  end

  assign alu_b = is_imm_op(op) ? imm : opnd_b;

  //////////////////////////////
  // alu

  always_comb begin
    case (op)
      op_add, op_addi: alu_out = opnd_a + alu_b;
      op_sub:          alu_out = opnd_a - alu_b;
      op_and:          alu_out = opnd_a & alu_b;
      op_or, op_ori:   alu_out = opnd_a | alu_b;
      op_xor:          alu_out = opnd_a ^ alu_b;
      op_slt: begin
        alu_out = {{(DATA_WIDTH-1){1'b0}}, ($signed(opnd_a) < $signed(alu_b))};
      end
      default:         alu_out = '0;
    endcase
  end

  // result register, also the forward source
  always_ff @(posedge clk) begin
    if (reset) begin
      result_we <= 1'b0;
    end else begin
      result_we <= we;
    end
  end

  always_ff @(posedge clk) begin
    result      <= alu_out;
    result_dest <= dest;
  end

endmodule

`default_nettype wire

// ==== rtl/isa_pkg.sv ====
`default_nettype none

package isa_pkg;

  localparam int INST_WIDTH     = 32;
  localparam int OPCODE_WIDTH   = 6;
  localparam int REG_ADDR_WIDTH = 5;
  localparam int IMM_WIDTH      = 16;

  // instruction fields
  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int RS_MSB     = 25;
  localparam int RS_LSB     = 21;
  localparam int RT_MSB     = 20;
  localparam int RT_LSB     = 16;
  localparam int RD_MSB     = 15;
  localparam int RD_LSB     = 11;

  typedef enum logic [OPCODE_WIDTH-1:0] {
    op_nop  = 6'h00,
    op_add  = 6'h01,
    op_sub  = 6'h02,
    op_and  = 6'h03,
    op_or   = 6'h04,
    op_xor  = 6'h05,
    // signed compare
    op_slt  = 6'h06,
    op_addi = 6'h08,
    op_ori  = 6'h0d
  } opcode_e;

  // register-register ops write rd, immediate ops write rt
  function automatic logic is_imm_op(opcode_e op);
    return (op == op_addi) || (op == op_ori);
  endfunction

endpackage

`default_nettype wire

// ==== rtl/issue_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module issue_unit
  import isa_pkg::*;
  import core_pkg::*;
(
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      inst_valid,
  input  logic [INST_WIDTH-1:0]     inst0,
  input  logic [INST_WIDTH-1:0]     inst1,
  output logic                      stall,
  output opcode_e                   lane_op   [NUM_LANES],
  output logic [REG_ADDR_WIDTH-1:0] lane_rs   [NUM_LANES],
  output logic [REG_ADDR_WIDTH-1:0] lane_rt   [NUM_LANES],
  output logic [REG_ADDR_WIDTH-1:0] lane_dest [NUM_LANES],
  output logic [DATA_WIDTH-1:0]     lane_imm  [NUM_LANES],
  output logic                      lane_we   [NUM_LANES]
);

  issue_state_e              state;
  logic [INST_WIDTH-1:0]     hold_inst;
  logic [INST_WIDTH-1:0]     src_inst    [NUM_LANES];
  opcode_e                   dec_op      [NUM_LANES];
  logic [REG_ADDR_WIDTH-1:0] dec_rs      [NUM_LANES];
  logic [REG_ADDR_WIDTH-1:0] dec_rt      [NUM_LANES];
  logic [REG_ADDR_WIDTH-1:0] dec_dest    [NUM_LANES];
  logic [DATA_WIDTH-1:0]     dec_imm     [NUM_LANES];
  logic                      dec_we      [NUM_LANES];
  logic                      dec_rt_used [NUM_LANES];
  logic                      accept;
  logic                      pair_dep;

  assign stall  = (state == issue_second);
  assign accept = inst_valid && (state == issue_pair);

  // lane 1 decodes the held instruction while the split drains
  assign src_inst[0] = inst0;
  assign src_inst[1] = (state == issue_second) ? hold_inst : inst1;

  //////////////////////////////
  // decode

  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      case (src_inst[i][OPCODE_MSB:OPCODE_LSB])
        op_add, op_sub, op_and, op_or, op_xor, op_slt, op_addi, op_ori:
          dec_op[i] = opcode_e'(src_inst[i][OPCODE_MSB:OPCODE_LSB]);
        default:
          dec_op[i] = op_nop;
      endcase
      dec_rs[i] = src_inst[i][RS_MSB:RS_LSB];
      dec_rt[i] = src_inst[i][RT_MSB:RT_LSB];
      if (dec_op[i] == op_ori) begin
        dec_imm[i] = {{(DATA_WIDTH-IMM_WIDTH){1'b0}}, src_inst[i][IMM_WIDTH-1:0]};
      end else begin
        dec_imm[i] = {{(DATA_WIDTH-IMM_WIDTH){src_inst[i][IMM_WIDTH-1]}},
                      src_inst[i][IMM_WIDTH-1:0]};
      end
      dec_dest[i]    = is_imm_op(dec_op[i]) ? dec_rt[i] : src_inst[i][RD_MSB:RD_LSB];
      dec_we[i]      = (dec_op[i] != op_nop) && (dec_dest[i] != '0);
      dec_rt_used[i] = (dec_op[i] != op_nop) && !is_imm_op(dec_op[i]);
    end
  end

  // inst1 reads what inst0 writes
  assign pair_dep = dec_we[0] && (dec_op[1] != op_nop) &&
                    ((dec_dest[0] == dec_rs[1]) ||
                     (dec_rt_used[1] && (dec_dest[0] == dec_rt[1])));

  //////////////////////////////
  // issue register

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= issue_pair;
      for (int i = 0; i < NUM_LANES; i++) begin
        lane_op[i] <= op_nop;
        lane_we[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        lane_op[i] <= op_nop;
        lane_we[i] <= 1'b0;
      end
      if (accept) begin
        lane_op[0] <= dec_op[0];
        lane_we[0] <= dec_we[0];
        if (!pair_dep) begin
          lane_op[1] <= dec_op[1];
          lane_we[1] <= dec_we[1];
        end
      end else if (state == issue_second) begin
        lane_op[1] <= dec_op[1];
        lane_we[1] <= dec_we[1];
      end
      state <= (accept && pair_dep) ? issue_second : issue_pair;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      lane_rs[i]   <= dec_rs[i];
      lane_rt[i]   <= dec_rt[i];
      lane_dest[i] <= dec_dest[i];
      lane_imm[i]  <= dec_imm[i];
    end
    if (accept && pair_dep) begin
      hold_inst <= inst1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/100ps
`default_nettype none

module register_file
  import core_pkg::*;
(
  input  logic                        clk,
  input  logic                        reset,
  input  logic [$clog2(NUM_REGS)-1:0] rd_addr_a [NUM_LANES],
  input  logic [$clog2(NUM_REGS)-1:0] rd_addr_b [NUM_LANES],
  output logic [DATA_WIDTH-1:0]       rd_data_a [NUM_LANES],
  output logic [DATA_WIDTH-1:0]       rd_data_b [NUM_LANES],
  input  logic                        wr_en     [NUM_LANES],
  input  logic [$clog2(NUM_REGS)-1:0] wr_addr   [NUM_LANES],
  input  logic [DATA_WIDTH-1:0]       wr_data   [NUM_LANES],
  output logic                        wb_valid  [NUM_LANES],
  output logic [$clog2(NUM_REGS)-1:0] wb_reg    [NUM_LANES],
  output logic [DATA_WIDTH-1:0]       wb_data   [NUM_LANES]
);

  logic [DATA_WIDTH-1:0] regs [NUM_REGS];

  // register 0 is never stored, the read mux returns zero
  always_comb begin
    for (int i = 0; i < NUM_LANES; i++) begin
      rd_data_a[i] = (rd_addr_a[i] == '0) ? '0 : regs[rd_addr_a[i]];
      rd_data_b[i] = (rd_addr_b[i] == '0) ? '0 : regs[rd_addr_b[i]];
    end
  end

  //////////////////////////////
  // write ports

  // lane order, higher lane lands last
  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      if (wr_en[i]) begin
        regs[wr_addr[i]] <= wr_data[i];
      end
    end
  end

  // writeback report
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        wb_valid[i] <= 1'b0;
      end
    end else begin
      for (int i = 0; i < NUM_LANES; i++) begin
        wb_valid[i] <= wr_en[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_LANES; i++) begin
      wb_reg[i]  <= wr_addr[i];
      wb_data[i] <= wr_data[i];
    end
  end

endmodule

`default_nettype wire

// ==== testbench/core_props.sv ====
`timescale 1ns/100ps
`default_nettype none

module core_props
  import isa_pkg::*;
  import core_pkg::*;
(
  input logic                      clk,
  input logic                      reset,
  input logic                      stall,
  input logic                      wb_valid [NUM_LANES],
  input logic [REG_ADDR_WIDTH-1:0] wb_reg   [NUM_LANES]
);

  // a split pair costs exactly one cycle
  stall_one_cycle: assert property (@(posedge clk) disable iff (reset) stall |=> !stall)
    else $error("stall stayed high for two consecutive cycles");

  stall_low_after_reset: assert property (@(posedge clk) reset |=> !stall)
    else $error("stall is high in the cycle after reset");

  for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
    // r0 writes never reach the report
    wb_not_r0: assert property (
      @(posedge clk) disable iff (reset) wb_valid[g] |-> (wb_reg[g] != '0))
      else $error("lane %0d reported a writeback to register 0", g);

    wb_low_after_reset: assert property (@(posedge clk) reset |=> !wb_valid[g])
      else $error("lane %0d wb_valid is high in the cycle after reset", g);
  end

endmodule

`default_nettype wire

// ==== testbench/core_vectors.hex ====
// columns: inst0 inst1 expected0 expected1
// the expected word of a nop or of a write to r0 is not checked
20010005 2002FFFD 00000005 FFFFFFFD
34038001 20048001 00008001 FFFF8001
04222800 08223000 00000002 00000008
14A63800 18414000 0000000A 00000001
0C644800 10645000 00008001 FFFF8001
18225800 18836000 00000000 00000001
200D0011 200D0022 00000011 00000022
05A07000 09A17800 00000022 0000001D
20300010 06108800 00000015 0000002A
20120100 08329800 00000100 FFFFFF05
0633A000 1612A800 FFFFFF2F 00000115
20200007 04220000 00000000 00000000
0401B000 1000B800 00000005 00000000
00000000 00000000 00000000 00000000
00000000 22D80003 00000000 00000008
0B16C800 00000000 00000003 00000000
20200009 0401D000 00000000 00000005
201B8000 341C7FFF FFFF8000 00007FFF
197CE800 199BF000 00000001 00000000
341FABCD 23E11111 0000ABCD 0000BCDE
10201000 17831000 0000BCDE 0000FFFE
04421800 08412000 0001FFFC 00004320
0C642800 10643000 00004320 0001FFFC
18A63800 04E74000 00000001 00000002
3509F000 20EAFFFF 0000F002 00000000
15265800 09496000 00010FFE FFFF0FFE
00000000 058B6800 00000000 00001FFC
21CE0001 21EFFFFF 00000023 0000001C
05CF8000 0A108800 0000003F 00000000
06309000 20100042 0000003F 00000042
06129800 1211A000 00000081 00000042
1673A800 1AB3B000 00000000 00000001
36D70100 22D80002 00000101 00000003
06F8C800 0EF8D000 00000104 00000001
0B3AD800 1737E000 00000103 00000005
077C0000 101BE800 00000000 00000103

// ==== testbench/tb_dual_issue_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_dual_issue_core
  import isa_pkg::*;
  import core_pkg::*;
();

  localparam int NUM_VECTORS    = 36;
  localparam int TIMEOUT_CYCLES = NUM_VECTORS * 6 + 20;

  logic                      clk;
  logic                      reset;
  logic                      inst_valid;
  logic [INST_WIDTH-1:0]     inst0;
  logic [INST_WIDTH-1:0]     inst1;
  logic                      stall;
  logic                      wb_valid [NUM_LANES];
  logic [REG_ADDR_WIDTH-1:0] wb_reg   [NUM_LANES];
  logic [DATA_WIDTH-1:0]     wb_data  [NUM_LANES];

  // each vector is four words inst0 inst1 expected0 expected1
  logic [31:0]               vec_mem  [NUM_VECTORS*4];

  // expected writebacks in program order
  logic [REG_ADDR_WIDTH-1:0] exp_reg_q  [$];
  logic [DATA_WIDTH-1:0]     exp_data_q [$];
  string                     exp_name_q [$];

  int                        value_errors;
  int                        other_errors;
  logic [31:0]               rng_state;
  int                        cur_vec;
  logic                      split_exp;
  string                     split_name;

  dual_issue_core dual_issue_core_inst (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .inst0      (inst0),
    .inst1      (inst1),
    .stall      (stall),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data)
  );

  bind dual_issue_core core_props core_props_inst (
    .clk      (clk),
    .reset    (reset),
    .stall    (stall),
    .wb_valid (wb_valid),
    .wb_reg   (wb_reg)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] s;
    s = x;
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // immediates write rt, register ops write rd, anything else writes nothing
  function automatic logic [REG_ADDR_WIDTH-1:0] dest_of(input logic [INST_WIDTH-1:0] inst);
    logic [OPCODE_WIDTH-1:0] opc;
    opc = inst[OPCODE_MSB:OPCODE_LSB];
    case (opc)
      op_addi, op_ori:                               return inst[RT_MSB:RT_LSB];
      op_add, op_sub, op_and, op_or, op_xor, op_slt: return inst[RD_MSB:RD_LSB];
      default:                                       return '0;
    endcase
  endfunction

  // a nop reads nothing, immediates read rs, register ops read rs and rt
  function automatic logic pair_splits(input logic [INST_WIDTH-1:0] first,
                                       input logic [INST_WIDTH-1:0] second);
    logic [REG_ADDR_WIDTH-1:0] dest;
    logic [OPCODE_WIDTH-1:0]   opc;
    dest = dest_of(first);
    opc  = second[OPCODE_MSB:OPCODE_LSB];
    if (dest == '0) begin
      return 1'b0;
    end
    case (opc)
      op_addi, op_ori:
        return second[RS_MSB:RS_LSB] == dest;
      op_add, op_sub, op_and, op_or, op_xor, op_slt:
        return (second[RS_MSB:RS_LSB] == dest) || (second[RT_MSB:RT_LSB] == dest);
      default:
        return 1'b0;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      value_errors++;
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
  endtask

  task automatic queue_expected(input int idx, input int slot);
    logic [REG_ADDR_WIDTH-1:0] dest;
    dest = dest_of(vec_mem[idx*4 + slot]);
    if (dest != '0) begin
      exp_reg_q.push_back(dest);
      exp_data_q.push_back(vec_mem[idx*4 + 2 + slot]);
      exp_name_q.push_back($sformatf("vector %0d inst%0d", idx, slot));
    end
  endtask

  //////////////////////////////
  // stimulus

  task automatic idle_cycles(input int count);
    repeat (count) begin
      @(posedge clk);
      inst_valid <= 1'b0;
    end
  endtask

  // a split pair stays on the inputs until stall drops
  task automatic send_pair(input int idx);
    @(posedge clk);
    cur_vec     = idx;
    inst_valid <= 1'b1;
    inst0      <= vec_mem[idx*4];
    inst1      <= vec_mem[idx*4 + 1];
    @(negedge clk);
    while (stall) begin
      @(negedge clk);
    end
  endtask

  initial begin
    int gap;
    reset        = 1'b1;
    inst_valid   = 1'b0;
    inst0        = '0;
    inst1        = '0;
    value_errors = 0;
    other_errors = 0;
    cur_vec      = 0;
    split_exp    = 1'b0;
    split_name   = "idle stall";
    rng_state    = 32'h1f08_d463;
    $readmemh("testbench/core_vectors.hex", vec_mem);
    for (int v = 0; v < NUM_VECTORS; v++) begin
      queue_expected(v, 0);
      queue_expected(v, 1);
    end
    repeat (3) @(posedge clk);
    reset <= 1'b0;
    for (int v = 0; v < NUM_VECTORS; v++) begin
      rng_state = next_random(rng_state);
      gap = rng_state % 3;
      idle_cycles(gap);
      send_pair(v);
    end
    idle_cycles(1);
    while (exp_reg_q.size() > 0) begin
      @(negedge clk);
    end
    // room for a stray pulse
    repeat (4) @(negedge clk);
    $display("errors: %0d value mismatches, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  //////////////////////////////
  // writeback monitor

  // lane 0 is older within a cycle
  always @(negedge clk) begin
    if (!reset) begin
      for (int i = 0; i < NUM_LANES; i++) begin
        if (wb_valid[i] === 1'b1) begin
          if (exp_reg_q.size() == 0) begin
            other_errors++;
            $display("ERROR: lane %0d wrote register %0d when no writeback was expected",
                     i, wb_reg[i]);
          end else begin
            check_value($sformatf("%s reg", exp_name_q[0]), exp_reg_q[0], wb_reg[i]);
            check_value($sformatf("%s data", exp_name_q[0]), exp_data_q[0], wb_data[i]);
            void'(exp_reg_q.pop_front());
            void'(exp_data_q.pop_front());
            void'(exp_name_q.pop_front());
          end
        end
      end
    end
  end

  //////////////////////////////
  // stall monitor

  // a pair seen with stall low is taken at the next rising edge
  always @(negedge clk) begin
    if (!reset) begin
      check_value(split_name, split_exp, stall);
      split_exp  = inst_valid && !stall && pair_splits(inst0, inst1);
      split_name = $sformatf("vector %0d stall", cur_vec);
    end
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("ERROR: watchdog expired after %0d cycles with %0d writebacks still missing",
             TIMEOUT_CYCLES, exp_reg_q.size());
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
rtl/isa_pkg.sv
rtl/core_pkg.sv
rtl/issue_unit.sv
rtl/exec_lane.sv
rtl/register_file.sv
rtl/dual_issue_core.sv
testbench/core_props.sv
testbench/tb_dual_issue_core.sv
